/* Bender.yml */
package:
  name: spacelaser_frontend

export_include_dirs:
  - include

sources:
  - files:
      - design/spacelaser_pkg.sv
      - design/player_controls.sv
      - design/overlay_colorizer.sv
      - design/sigma_delta_dac.sv
      - design/spacelaser_frontend.sv
  - target: simulation
    files:
      - tb/tb_spacelaser_frontend.sv

/* design/overlay_colorizer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spacelaser_defs.svh"

module overlay_colorizer (
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  video,
	input  wire  hsync,
	input  wire  vsync,
	input  wire  overlay_en,
	output logic r,
	output logic g,
	output logic b,
	output logic hs,
	output logic vs
);

	spacelaser_pkg::hcount_t hcount;
	spacelaser_pkg::band_t   band;

	logic       video_q; // pixel bit seen by the output stage
	logic [2:0] band_rgb;
	logic [2:0] pix_rgb;

	// column counter clears during hsync and holds at the top
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hcount <= '0;
		end else if (hsync) begin
			hcount <= '0;
		end else if (hcount != '1) begin
			hcount <= hcount + 1'b1;
		end
	end

	always_comb begin
		if (hcount < `SL_HCOUNT_W'(`SL_BAND_LO)) begin
			band = spacelaser_pkg::band_green;
		end else if (hcount < `SL_HCOUNT_W'(`SL_BAND_HI)) begin
			band = spacelaser_pkg::band_white;
		end else begin
			band = spacelaser_pkg::band_red;
		end
	end

	// {r,g,b} for each strip
	always_comb begin
		case (band)
			spacelaser_pkg::band_green: band_rgb = 3'b010;
			spacelaser_pkg::band_red:   band_rgb = 3'b100;
			default:                    band_rgb = 3'b111;
		endcase
	end

	always_comb begin
		if (!video) begin
			pix_rgb = 3'b000;
		end else if (overlay_en) begin
			pix_rgb = band_rgb;
		end else begin
			pix_rgb = 3'b111; // plain white monitor
		end
	end

	// colour and syncs share one register stage
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			r       <= 1'b0;
			g       <= 1'b0;
			b       <= 1'b0;
			hs      <= 1'b0;
			vs      <= 1'b0;
			video_q <= 1'b0;
		end else begin
			{r, g, b} <= pix_rgb;
			hs        <= hsync;
			vs        <= vsync;
			video_q   <= video;
		end
	end

	a_black_when_off: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!video_q |-> !(r | g | b)
	);

endmodule

`default_nettype wire

/* design/player_controls.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spacelaser_defs.svh"

module player_controls (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire                     key_strobe,
	input  wire                     key_pressed,
	input  spacelaser_pkg::scancode_t key_code,
	input  spacelaser_pkg::joy_t    joystick_0,
	input  spacelaser_pkg::joy_t    joystick_1,
	input  wire                     rotate,
	output logic                    coin,
	output logic                    start1,
	output logic                    start2,
	output logic                    fire,
	output logic                    move_left,
	output logic                    move_right
);

	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic btn_coin;
	logic btn_start1;
	logic btn_start2;
	logic btn_fire;

	logic joy_up;
	logic joy_down;
	logic joy_left;
	logic joy_right;
	logic joy_fire;

	// make sets, break clears
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
			btn_fire   <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				`SL_KEY_UP:     btn_up     <= key_pressed;
				`SL_KEY_DOWN:   btn_down   <= key_pressed;
				`SL_KEY_LEFT:   btn_left   <= key_pressed;
				`SL_KEY_RIGHT:  btn_right  <= key_pressed;
				`SL_KEY_COIN:   btn_coin   <= key_pressed;
				`SL_KEY_START1: btn_start1 <= key_pressed;
				`SL_KEY_START2: btn_start2 <= key_pressed;
				`SL_KEY_FIRE:   btn_fire   <= key_pressed;
				default: ; // other keys ignored
			endcase
		end
	end

	// either stick may drive the game
	assign joy_up    = joystick_0[`SL_JOY_UP]    | joystick_1[`SL_JOY_UP];
	assign joy_down  = joystick_0[`SL_JOY_DOWN]  | joystick_1[`SL_JOY_DOWN];
	assign joy_left  = joystick_0[`SL_JOY_LEFT]  | joystick_1[`SL_JOY_LEFT];
	assign joy_right = joystick_0[`SL_JOY_RIGHT] | joystick_1[`SL_JOY_RIGHT];
	assign joy_fire  = joystick_0[`SL_JOY_FIRE]  | joystick_1[`SL_JOY_FIRE];

	assign coin   = btn_coin;
	assign start1 = btn_start1;
	assign start2 = btn_start2;
	assign fire   = btn_fire | joy_fire;

	// unrotated monitor is sideways, so up/down steer the cannon
	always_comb begin
		if (rotate) begin
			move_left  = btn_left | joy_left;
			move_right = btn_right | joy_right;
		end else begin
			move_left  = btn_up | joy_up;
			move_right = btn_down | joy_down;
		end
	end

	a_code_known: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		key_strobe |-> !$isunknown(key_code)
	);

endmodule

`default_nettype wire

/* design/sigma_delta_dac.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spacelaser_defs.svh"

module sigma_delta_dac (
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  spacelaser_pkg::audio_t audio_in,
	output logic                   pdm_out
);

	logic [`SL_AUDIO_W:0] acc; // msb is the carry of the last add

	// residue stays in the low bits, carry out is the pulse
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[`SL_AUDIO_W-1:0]} + {1'b0, audio_in};
		end
	end

	assign pdm_out = acc[`SL_AUDIO_W];

	a_pdm_known: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!$isunknown(pdm_out)
	);

endmodule

`default_nettype wire

/* design/spacelaser_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

module spacelaser_frontend (
	input  wire                       clk_sys,
	input  wire                       rst_n,
	// keyboard and joysticks
	input  wire                       key_strobe,
	input  wire                       key_pressed,
	input  spacelaser_pkg::scancode_t key_code,
	input  spacelaser_pkg::joy_t      joystick_0,
	input  spacelaser_pkg::joy_t      joystick_1,
	input  wire                       rotate,
	output logic                      coin,
	output logic                      start1,
	output logic                      start2,
	output logic                      fire,
	output logic                      move_left,
	output logic                      move_right,
	// video from the core
	input  wire                       video,
	input  wire                       hsync,
	input  wire                       vsync,
	input  wire                       overlay_en,
	output logic                      r,
	output logic                      g,
	output logic                      b,
	output logic                      hs,
	output logic                      vs,
	// audio
	input  spacelaser_pkg::audio_t    audio_in,
	output logic                      pdm_out
);

	player_controls controls_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.key_strobe (key_strobe),
		.key_pressed(key_pressed),
		.key_code   (key_code),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.coin       (coin),
		.start1     (start1),
		.start2     (start2),
		.fire       (fire),
		.move_left  (move_left),
		.move_right (move_right)
	);

	overlay_colorizer overlay_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.video     (video),
		.hsync     (hsync),
		.vsync     (vsync),
		.overlay_en(overlay_en),
		.r         (r),
		.g         (g),
		.b         (b),
		.hs        (hs),
		.vs        (vs)
	);

	sigma_delta_dac dac_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.audio_in(audio_in),
		.pdm_out (pdm_out)
	);

endmodule

`default_nettype wire

/* design/spacelaser_pkg.sv */
`default_nettype none

`include "spacelaser_defs.svh"

package spacelaser_pkg;

	typedef logic [7:0] scancode_t; // ps/2 code

	typedef logic [7:0] joy_t; // bit order per SL_JOY_* macros

	typedef logic [`SL_AUDIO_W-1:0] audio_t; // unsigned sample

	typedef logic [`SL_HCOUNT_W-1:0] hcount_t;

	// overlay strip colours from left to right across the screen
	typedef enum logic [1:0] {
		band_green,
		band_white,
		band_red
	} band_t;

endpackage

`default_nettype wire

/* include/spacelaser_defs.svh */
`ifndef SPACELASER_DEFS_SVH
`define SPACELASER_DEFS_SVH

// PS/2 set 2 make codes as delivered by the keyboard link
`define SL_KEY_UP      8'h75 // keypad 8 / arrow up
`define SL_KEY_DOWN    8'h72
`define SL_KEY_LEFT    8'h6B
`define SL_KEY_RIGHT   8'h74
`define SL_KEY_COIN    8'h76 // esc
`define SL_KEY_START1  8'h05 // f1
`define SL_KEY_START2  8'h06 // f2
`define SL_KEY_FIRE    8'h29 // space

// joystick word bit positions
`define SL_JOY_RIGHT   0
`define SL_JOY_LEFT    1
`define SL_JOY_DOWN    2
`define SL_JOY_UP      3
`define SL_JOY_FIRE    4

// cellophane strip edges in pixel columns after hsync
`define SL_BAND_LO     32
`define SL_BAND_HI     184

// datapath widths
`define SL_AUDIO_W     8
`define SL_HCOUNT_W    9

`endif

/* spacelaser_frontend.f */
+incdir+include
design/spacelaser_pkg.sv
design/player_controls.sv
design/overlay_colorizer.sv
design/sigma_delta_dac.sv
design/spacelaser_frontend.sv
tb/tb_spacelaser_frontend.sv

/* tb/tb_spacelaser_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spacelaser_defs.svh"

module tb_spacelaser_frontend;

	logic clk_sys = 1'b0;
	logic rst_n;
	logic key_strobe;
	logic key_pressed;
	spacelaser_pkg::scancode_t key_code;
	spacelaser_pkg::joy_t joystick_0;
	spacelaser_pkg::joy_t joystick_1;
	logic rotate;
	logic video;
	logic hsync;
	logic vsync;
	logic overlay_en;
	spacelaser_pkg::audio_t audio_in;
	logic coin;
	logic start1;
	logic start2;
	logic fire;
	logic move_left;
	logic move_right;
	logic r;
	logic g;
	logic b;
	logic hs;
	logic vs;
	logic pdm_out;

	logic [7:0] latch_m; // up down left right coin start1 start2 fire
	spacelaser_pkg::hcount_t hcount_m;
	logic [2:0] rgb_m;
	logic hs_m;
	logic vs_m;
	logic in_rst;
	logic [31:0] rng = 32'd49;
	int errors = 0;
	int checks = 0;

	always #20 clk_sys = ~clk_sys;

	spacelaser_frontend dut_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.key_strobe (key_strobe),
		.key_pressed(key_pressed),
		.key_code   (key_code),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.coin       (coin),
		.start1     (start1),
		.start2     (start2),
		.fire       (fire),
		.move_left  (move_left),
		.move_right (move_right),
		.video      (video),
		.hsync      (hsync),
		.vsync      (vsync),
		.overlay_en (overlay_en),
		.r          (r),
		.g          (g),
		.b          (b),
		.hs         (hs),
		.vs         (vs),
		.audio_in   (audio_in),
		.pdm_out    (pdm_out)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// latch slot for a scancode or -1 when the game ignores it
	function automatic int key_index(input spacelaser_pkg::scancode_t code);
		case (code)
			`SL_KEY_UP:     return 0;
			`SL_KEY_DOWN:   return 1;
			`SL_KEY_LEFT:   return 2;
			`SL_KEY_RIGHT:  return 3;
			`SL_KEY_COIN:   return 4;
			`SL_KEY_START1: return 5;
			`SL_KEY_START2: return 6;
			`SL_KEY_FIRE:   return 7;
			default:        return -1;
		endcase
	endfunction

	// {coin, start1, start2, fire, move_left, move_right}
	function automatic logic [5:0] expected_controls(input logic [7:0] lat,
			input spacelaser_pkg::joy_t j0, input spacelaser_pkg::joy_t j1, input logic rot);
		spacelaser_pkg::joy_t j;
		logic ml;
		logic mr;
		j = j0 | j1;
		if (rot) begin
			ml = lat[2] | j[`SL_JOY_LEFT];
			mr = lat[3] | j[`SL_JOY_RIGHT];
		end else begin
			ml = lat[0] | j[`SL_JOY_UP];
			mr = lat[1] | j[`SL_JOY_DOWN];
		end
		return {lat[4], lat[5], lat[6], lat[7] | j[`SL_JOY_FIRE], ml, mr};
	endfunction

	function automatic logic [2:0] expected_rgb(input logic vid, input logic en,
			input spacelaser_pkg::hcount_t hc);
		if (!vid) return 3'b000;
		if (!en) return 3'b111;
		if (hc < `SL_BAND_LO) return 3'b010; // green strip
		if (hc < `SL_BAND_HI) return 3'b111;
		return 3'b100;
	endfunction

	// pulse density is level/256
	function automatic int density_ones(input spacelaser_pkg::audio_t level);
		return int'(level);
	endfunction

	// reference state follows the same clock edge as the DUT
	always @(posedge clk_sys) begin
		in_rst <= !rst_n;
		if (!rst_n) begin
			latch_m  <= '0;
			hcount_m <= '0;
			rgb_m    <= '0;
			hs_m     <= 1'b0;
			vs_m     <= 1'b0;
		end else begin
			if (key_strobe && key_index(key_code) >= 0) begin
				latch_m[key_index(key_code)] <= key_pressed;
			end
			rgb_m <= expected_rgb(video, overlay_en, hcount_m);
			hs_m  <= hsync;
			vs_m  <= vsync;
			if (hsync) begin
				hcount_m <= '0;
			end else if (hcount_m != '1) begin
				hcount_m <= hcount_m + 1'b1;
			end
		end
	end

	task automatic compare_value(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		checks++;
		assert (act === exp) else begin
			$display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	// outputs are settled half a period after the driving edge
	always @(negedge clk_sys) begin
		logic [5:0] exp_ctl;
		exp_ctl = expected_controls(latch_m, joystick_0, joystick_1, rotate);
		compare_value("coin", exp_ctl[5], coin);
		compare_value("start1", exp_ctl[4], start1);
		compare_value("start2", exp_ctl[3], start2);
		compare_value("fire", exp_ctl[2], fire);
		compare_value("move_left", exp_ctl[1], move_left);
		compare_value("move_right", exp_ctl[0], move_right);
		compare_value("r", rgb_m[2], r);
		compare_value("g", rgb_m[1], g);
		compare_value("b", rgb_m[0], b);
		compare_value("hs", hs_m, hs);
		compare_value("vs", vs_m, vs);
		if (in_rst) begin
			compare_value("pdm_out", 16'h0, pdm_out);
		end
	end

	task automatic apply_reset(input spacelaser_pkg::audio_t level);
		@(posedge clk_sys);
		rst_n       <= 1'b0;
		key_strobe  <= 1'b0;
		key_pressed <= 1'b0;
		key_code    <= '0;
		joystick_0  <= '0;
		joystick_1  <= '0;
		rotate      <= 1'b0;
		video       <= 1'b0;
		hsync       <= 1'b0;
		vsync       <= 1'b0;
		overlay_en  <= 1'b0;
		audio_in    <= level;
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
	endtask

	task automatic key_event(input spacelaser_pkg::scancode_t code, input logic pressed);
		@(posedge clk_sys);
		key_strobe  <= 1'b1;
		key_code    <= code;
		key_pressed <= pressed;
		@(posedge clk_sys);
		key_strobe <= 1'b0;
	endtask

	task automatic sync_pulse();
		int n;
		@(posedge clk_sys);
		hsync <= 1'b1;
		@(posedge clk_sys);
		hsync <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (!hs && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (!hs) begin
			$display("timeout: hs never followed the hsync pulse");
			errors++;
		end
	endtask

	initial begin
		int rot;
		int c;
		int i;
		int ones;
		spacelaser_pkg::audio_t level;
		rst_n       = 1'b0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		joystick_0  = '0;
		joystick_1  = '0;
		rotate      = 1'b0;
		video       = 1'b0;
		hsync       = 1'b0;
		vsync       = 1'b0;
		overlay_en  = 1'b0;
		audio_in    = '0;
		apply_reset(8'h00);

		// every code made and broken whether listed or not
		for (rot = 0; rot < 2; rot++) begin
			@(posedge clk_sys);
			rotate <= rot[0];
			for (c = 0; c < 256; c++) begin
				key_event(c[7:0], 1'b1);
				key_event(c[7:0], 1'b0);
			end
		end

		for (i = 0; i < 6; i++) begin
			for (c = 0; c < 256; c++) begin
				if (key_index(c[7:0]) >= 0) begin
					rng = xorshift32(rng);
					key_event(c[7:0], rng[0]);
				end
			end
			repeat (32) begin
				@(posedge clk_sys);
				rng = xorshift32(rng);
				joystick_0 <= rng[7:0];
				joystick_1 <= rng[15:8];
				rotate     <= rng[16];
			end
		end
		@(posedge clk_sys);
		joystick_0 <= '0;
		joystick_1 <= '0;

		for (i = 0; i < 2; i++) begin
			@(posedge clk_sys);
			overlay_en <= i[0];
			sync_pulse();
			repeat (300) begin
				@(posedge clk_sys);
				rng = xorshift32(rng);
				video <= rng[3];
				vsync <= rng[8] & rng[9];
			end
		end

		for (i = 0; i < 6; i++) begin
			rng = xorshift32(rng);
			level = (i == 0) ? 8'h00 : (i == 1) ? 8'hFF : rng[7:0];
			apply_reset(level);
			ones = 0;
			@(negedge clk_sys);
			@(negedge clk_sys); // first output carries no sample yet
			repeat (256) begin
				@(negedge clk_sys);
				ones += pdm_out;
			end
			compare_value("pdm_out ones", density_ones(level), ones);
		end

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
